// File: hdl/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

    localparam int PAYLOAD_BITS = 8;
    localparam int CLKS_PER_BIT = 16;  // Kept small for short runs.
    localparam int FIFO_DEPTH   = 8;
    localparam int LEVEL_BITS   = 4;   // Counts 0 to FIFO_DEPTH.
    localparam int PTR_BITS     = 3;

    // Start bit, payload, stop bit.
    localparam int FRAME_BITS   = PAYLOAD_BITS + 2;
    localparam int BIT_CNT_BITS = 4;
    localparam int CLK_CNT_BITS = 4;

endpackage

`default_nettype wire

// File: hdl/uart_bus_pkg.sv
`default_nettype none

package uart_bus_pkg;

    localparam logic [3:0] REG_DATA   = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;

    localparam int ST_TX_FULL   = 0;
    localparam int ST_RX_EMPTY  = 1;
    localparam int ST_FRAME_ERR = 2;
    localparam int ST_OVERRUN   = 3;
    localparam int ST_TX_LEVEL  = 8;   // Low bit of the 4-bit field.
    localparam int ST_RX_LEVEL  = 16;  // Low bit of the 4-bit field.

    // Flags a data read that found the receive queue empty.
    localparam int RD_EMPTY_FLAG = 8;

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        WAIT_SPACE,
        RESPOND
    } bus_state_t;

endpackage

`default_nettype wire

// File: hdl/byte_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface byte_chan_if;
    import uart_cfg_pkg::*;

    logic [PAYLOAD_BITS-1:0] data;
    logic                    valid;
    logic                    ready;
    logic [LEVEL_BITS-1:0]   level;  // Always driven by the path side.

    modport producer (
        output data, valid, level,
        input  ready
    );

    modport consumer (
        input  data, valid,
        output ready, level
    );

endinterface

`default_nettype wire

// File: hdl/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  push,
    input  logic                                  pop,
    input  logic [uart_cfg_pkg::PAYLOAD_BITS-1:0] push_data,
    output logic [uart_cfg_pkg::PAYLOAD_BITS-1:0] pop_data,
    output logic                                  full,
    output logic                                  empty,
    output logic [uart_cfg_pkg::LEVEL_BITS-1:0]   level
);
    import uart_cfg_pkg::*;

    logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]     wr_ptr;   // Wraps at FIFO_DEPTH.
    logic [PTR_BITS-1:0]     rd_ptr;
    logic [LEVEL_BITS-1:0]   count;
    logic                    do_push;
    logic                    do_pop;

    assign do_push  = push && !full;   // Push on full is dropped.
    assign do_pop   = pop && !empty;
    assign full     = (count == LEVEL_BITS'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign level    = count;
    assign pop_data = mem[rd_ptr];     // Head shown without a pop.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_tx_path.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_path (
    input  logic          clk,
    input  logic          reset,
    byte_chan_if.consumer chan,
    output logic          tx
);
    import uart_cfg_pkg::*;

    typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

    tx_state_t               state;
    logic [PAYLOAD_BITS-1:0] fifo_data;
    logic                    fifo_empty;
    logic                    fifo_full;
    logic [PAYLOAD_BITS:0]   shreg;      // Data bits, then the stop bit.
    logic [CLK_CNT_BITS-1:0] clk_cnt;
    logic [BIT_CNT_BITS-1:0] bit_cnt;
    logic                    bit_end;
    logic                    frame_end;
    logic                    load;

    byte_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (chan.valid),
        .pop       (load),
        .push_data (chan.data),
        .pop_data  (fifo_data),
        .full      (fifo_full),
        .empty     (fifo_empty),
        .level     (chan.level)
    );

    assign chan.ready = !fifo_full;

    assign bit_end   = (state == TX_SEND) && (clk_cnt == CLK_CNT_BITS'(CLKS_PER_BIT - 1));
    assign frame_end = bit_end && (bit_cnt == BIT_CNT_BITS'(FRAME_BITS - 1));
    // Next frame starts right after the stop bit when data is waiting.
    assign load      = ((state == TX_IDLE) || frame_end) && !fifo_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            tx      <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (load) begin
            state   <= TX_SEND;
            tx      <= 1'b0;             // Start bit.
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (frame_end) begin
            state   <= TX_IDLE;
            tx      <= 1'b1;
        end else if (bit_end) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            tx      <= shreg[0];         // LSB first.
        end else if (state == TX_SEND) begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {1'b1, fifo_data};
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[PAYLOAD_BITS:1]};
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_rx_path.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_path (
    input  logic          clk,
    input  logic          reset,
    input  logic          rx,
    byte_chan_if.producer chan,
    output logic          frame_err_pulse,
    output logic          overrun_pulse
);
    import uart_cfg_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t               state;
    logic                    rx_meta;
    logic                    rx_sync;
    logic                    rx_prev;
    logic                    start_edge;
    logic                    half_bit;
    logic                    full_bit;
    logic                    stop_sample;
    logic                    push;
    logic                    fifo_empty;
    logic                    fifo_full;
    logic [PAYLOAD_BITS-1:0] shreg;
    logic [CLK_CNT_BITS-1:0] clk_cnt;
    logic [BIT_CNT_BITS-1:0] bit_cnt;

    byte_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .pop       (chan.ready),
        .push_data (shreg),
        .pop_data  (chan.data),
        .full      (fifo_full),
        .empty     (fifo_empty),
        .level     (chan.level)
    );

    assign chan.valid = !fifo_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;             // Line idles high.
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Edge only, so a line held low after a bad stop bit does not retrigger.
    assign start_edge  = rx_prev && !rx_sync;
    assign half_bit    = (clk_cnt == CLK_CNT_BITS'(CLKS_PER_BIT / 2 - 1));
    assign full_bit    = (clk_cnt == CLK_CNT_BITS'(CLKS_PER_BIT - 1));
    assign stop_sample = (state == RX_STOP) && full_bit;
    assign push        = stop_sample && rx_sync && !fifo_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= RX_IDLE;
            clk_cnt         <= '0;
            bit_cnt         <= '0;
            frame_err_pulse <= 1'b0;
            overrun_pulse   <= 1'b0;
        end else begin
            frame_err_pulse <= stop_sample && !rx_sync;
            overrun_pulse   <= stop_sample && rx_sync && fifo_full;
            clk_cnt         <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_bit) begin      // Mid start bit.
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (full_bit) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_CNT_BITS'(PAYLOAD_BITS - 1)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (full_bit) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == RX_DATA) && full_bit) begin
            shreg <= {rx_sync, shreg[PAYLOAD_BITS-1:1]};  // LSB arrives first.
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bus_regs (
    input  logic          clk,
    input  logic          reset,
    input  logic          read,
    input  logic          write,
    input  logic [3:0]    address,
    input  logic [31:0]   write_data,
    output logic [31:0]   read_data,
    output logic          response,
    byte_chan_if.producer tx_chan,
    byte_chan_if.consumer rx_chan,
    input  logic          frame_err_pulse,
    input  logic          overrun_pulse
);
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    bus_state_t              state;
    logic                    req_read;
    logic [3:0]              req_addr;
    logic [PAYLOAD_BITS-1:0] req_byte;
    logic                    accept;
    logic                    data_write;
    logic                    data_read;
    logic                    status_read;
    logic                    frame_err_flag;
    logic                    overrun_flag;
    logic [31:0]             status_word;

    assign accept      = (read || write) && ((state == IDLE) || (state == RESPOND));
    assign data_write  = (state == DECODE) && !req_read && (req_addr == REG_DATA);
    assign data_read   = (state == DECODE) && req_read && (req_addr == REG_DATA);
    assign status_read = (state == DECODE) && req_read && (req_addr == REG_STATUS);

    assign tx_chan.data  = req_byte;
    assign tx_chan.valid = data_write || (state == WAIT_SPACE);
    assign rx_chan.ready = data_read && rx_chan.valid;  // Pop the head.
    assign response      = (state == RESPOND);

    always_comb begin
        status_word                               = '0;
        status_word[ST_TX_FULL]                   = !tx_chan.ready;
        status_word[ST_RX_EMPTY]                  = !rx_chan.valid;
        status_word[ST_FRAME_ERR]                 = frame_err_flag;
        status_word[ST_OVERRUN]                   = overrun_flag;
        status_word[ST_TX_LEVEL +: LEVEL_BITS]    = tx_chan.level;
        status_word[ST_RX_LEVEL +: LEVEL_BITS]    = rx_chan.level;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE, RESPOND: state <= accept ? DECODE : IDLE;
                DECODE: begin
                    if (data_write && !tx_chan.ready) begin
                        state <= WAIT_SPACE;     // Hold the write until space.
                    end else begin
                        state <= RESPOND;
                    end
                end
                WAIT_SPACE: begin
                    if (tx_chan.ready) begin
                        state <= RESPOND;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_read <= read && !write;          // Write wins a double strobe.
            req_addr <= address;
            req_byte <= write_data[PAYLOAD_BITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if ((state == DECODE) && req_read) begin
            read_data <= '0;
            if (data_read) begin
                if (rx_chan.valid) begin
                    read_data[PAYLOAD_BITS-1:0] <= rx_chan.data;
                end else begin
                    read_data[RD_EMPTY_FLAG] <= 1'b1;
                end
            end else if (status_read) begin
                read_data <= status_word;
            end
        end
    end

    // Sticky flags; a new event beats the clear.
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_err_flag <= 1'b0;
            overrun_flag   <= 1'b0;
        end else begin
            frame_err_flag <= frame_err_pulse || (frame_err_flag && !status_read);
            overrun_flag   <= overrun_pulse || (overrun_flag && !status_read);
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_periph.sv
`timescale 1ns/1ps
`default_nettype none

module uart_periph (
    input  logic        clk,
    input  logic        reset,
    input  logic        rx,
    output logic        tx,
    input  logic        read,
    input  logic        write,
    input  logic [3:0]  address,
    input  logic [31:0] write_data,
    output logic [31:0] read_data,
    output logic        response
);

    logic frame_err_pulse;
    logic overrun_pulse;

    byte_chan_if tx_chan ();
    byte_chan_if rx_chan ();

    uart_bus_regs u_regs (
        .clk             (clk),
        .reset           (reset),
        .read            (read),
        .write           (write),
        .address         (address),
        .write_data      (write_data),
        .read_data       (read_data),
        .response        (response),
        .tx_chan         (tx_chan.producer),
        .rx_chan         (rx_chan.consumer),
        .frame_err_pulse (frame_err_pulse),
        .overrun_pulse   (overrun_pulse)
    );

    uart_tx_path u_tx (
        .clk   (clk),
        .reset (reset),
        .chan  (tx_chan.consumer),
        .tx    (tx)
    );

    uart_rx_path u_rx (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx),
        .chan            (rx_chan.producer),
        .frame_err_pulse (frame_err_pulse),
        .overrun_pulse   (overrun_pulse)
    );

endmodule

`default_nettype wire

// File: test/uart_periph_assert.sv
`timescale 1ns/1ps
`default_nettype none

module uart_periph_assert (
    input logic                     clk,
    input logic                     reset,
    input logic                     read,
    input logic                     write,
    input logic                     response,
    input logic                     tx,
    input uart_bus_pkg::bus_state_t state
);
    import uart_bus_pkg::*;

    response_single: assert property (
        @(posedge clk) disable iff (reset) response |=> !response
    ) else $error("response stayed high for two cycles");

    // Line held idle while in reset.
    tx_idle_in_reset: assert property (
        @(posedge clk) reset && $past(reset) |-> tx
    ) else $error("tx low during reset");

    response_latency: assert property (
        @(posedge clk) disable iff (reset)
        (read || write) |-> ##2 (response || (state == WAIT_SPACE))
    ) else $error("no response two cycles after a bus strobe");

endmodule

bind uart_periph uart_periph_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .read     (read),
    .write    (write),
    .response (response),
    .tx       (tx),
    .state    (u_regs.state)
);

`default_nettype wire

// File: test/uart_periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_periph_tb;
    import uart_cfg_pkg::*;
    import uart_bus_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int FRAME_COUNT = 28;   // 5 + 12 + 1 + 10 frames.
    localparam int FRAME_NS    = FRAME_BITS * CLKS_PER_BIT * CLK_PERIOD;
    localparam int WATCHDOG_NS = FRAME_COUNT * FRAME_NS * 3 / 2;

    typedef enum int {CHK_NONE, CHK_BYTE, CHK_WORD} chk_kind_t;

    logic        clk;
    logic        reset;
    logic        rx;
    logic        tx;
    logic        read;
    logic        write;
    logic [3:0]  address;
    logic [31:0] write_data;
    logic [31:0] read_data;
    logic        response;
    logic        loop_en;
    logic        rx_drive;

    // Expected result for each bus request, in issue order.
    chk_kind_t               exp_kind [$];
    logic [31:0]             exp_value [$];
    string                   exp_name [$];
    int                      issued;
    int                      checked;

    // Queue model of both FIFOs and the sticky flags.
    logic [PAYLOAD_BITS-1:0] tx_q [$];
    logic [PAYLOAD_BITS-1:0] rx_q [$];
    logic                    frame_m;
    logic                    overrun_m;

    assign rx = loop_en ? tx : rx_drive;   // Loopback or direct drive.

    uart_periph u_dut (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .tx         (tx),
        .read       (read),
        .write      (write),
        .address    (address),
        .write_data (write_data),
        .read_data  (read_data),
        .response   (response)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns.", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired.");
    end

    function automatic logic [31:0] ref_status();
        logic [31:0] word;
        word                              = '0;
        word[ST_TX_FULL]                  = (tx_q.size() >= FIFO_DEPTH);
        word[ST_RX_EMPTY]                 = (rx_q.size() == 0);
        word[ST_FRAME_ERR]                = frame_m;
        word[ST_OVERRUN]                  = overrun_m;
        word[ST_TX_LEVEL +: LEVEL_BITS]   = LEVEL_BITS'(tx_q.size());
        word[ST_RX_LEVEL +: LEVEL_BITS]   = LEVEL_BITS'(rx_q.size());
        return word;
    endfunction

    task automatic check_byte(input string name, input logic [PAYLOAD_BITS-1:0] expected,
                              input logic [PAYLOAD_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Byte mismatch in %s.", name);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Word mismatch in %s.", name);
        end
    endtask

    // One-cycle strobe, then wait for the response pulse.
    task automatic bus_strobe(input logic is_read, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clk);
        read       = is_read;
        write      = !is_read;
        address    = addr;
        write_data = wdata;
        @(negedge clk);
        read  = 1'b0;
        write = 1'b0;
        while (!response) @(negedge clk);
        rdata = read_data;
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] wdata,
                             input string name);
        logic [31:0] rd;
        exp_kind.push_back(CHK_NONE);
        exp_value.push_back('0);
        exp_name.push_back(name);
        issued++;
        bus_strobe(1'b0, addr, wdata, rd);
    endtask

    task automatic bus_read(input logic [3:0] addr, input chk_kind_t kind,
                            input logic [31:0] expected, input string name,
                            output logic [31:0] rdata);
        exp_kind.push_back(kind);
        exp_value.push_back(expected);
        exp_name.push_back(name);
        issued++;
        bus_strobe(1'b1, addr, '0, rdata);
    endtask

    task automatic check_status(input string name);
        logic [31:0] rd;
        bus_read(REG_STATUS, CHK_WORD, ref_status(), name, rd);
        frame_m   = 1'b0;                  // Status read clears them.
        overrun_m = 1'b0;
    endtask

    task automatic check_rx_byte(input string name);
        logic [31:0] rd;
        bus_read(REG_DATA, CHK_BYTE, 32'(rx_q.pop_front()), name, rd);
    endtask

    task automatic wait_rx_level(input int count);
        logic [31:0] rd;
        do begin
            bus_read(REG_STATUS, CHK_NONE, '0, "rx_poll", rd);
        end while (rd[ST_RX_LEVEL +: LEVEL_BITS] < LEVEL_BITS'(count));
    endtask

    task automatic send_frame(input logic [PAYLOAD_BITS-1:0] data, input logic stop_bit);
        logic [FRAME_BITS-1:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(negedge clk);
            rx_drive = bits[i];
            repeat (CLKS_PER_BIT - 1) @(negedge clk);
        end
        @(negedge clk);
        rx_drive = 1'b1;
    endtask

    initial begin
        chk_kind_t   kind;
        logic [31:0] expected;
        string       name;
        forever begin
            @(negedge clk);
            if (response) begin
                if (exp_kind.size() == 0) begin
                    $display("A response arrived with no bus request outstanding.");
                    $display("TESTS FAILED");
                    $fatal(1, "Unexpected response.");
                end else begin
                    kind     = exp_kind.pop_front();
                    expected = exp_value.pop_front();
                    name     = exp_name.pop_front();
                    case (kind)
                        CHK_BYTE: check_byte(name, expected[PAYLOAD_BITS-1:0],
                                             read_data[PAYLOAD_BITS-1:0]);
                        CHK_WORD: check_word(name, expected, read_data);
                        default:  ;
                    endcase
                    checked++;
                end
            end
        end
    end

    initial begin
        logic [PAYLOAD_BITS-1:0] b;
        logic [31:0]             rd;
        void'($urandom(2));
        reset      = 1'b1;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        write_data = '0;
        loop_en    = 1'b0;                 // Line idles high until tx leaves reset.
        rx_drive   = 1'b1;
        frame_m    = 1'b0;
        overrun_m  = 1'b0;
        issued     = 0;
        checked    = 0;
        repeat (3) @(negedge clk);
        reset   = 1'b0;
        loop_en = 1'b1;

        check_status("reset_status");
        bus_read(REG_DATA, CHK_WORD, 32'(1) << RD_EMPTY_FLAG, "reset_empty_read", rd);

        for (int i = 0; i < 5; i++) begin
            b = PAYLOAD_BITS'($urandom);
            tx_q.push_back(b);
            bus_write(REG_DATA, 32'(b), "loop_write");
        end
        wait_rx_level(5);
        while (tx_q.size() > 0) rx_q.push_back(tx_q.pop_front());
        for (int i = 0; i < 5; i++) begin
            check_rx_byte("loop_read");
        end
        check_status("loop_status");

        // Transmit FIFO fills while the first frames drain into the receiver.
        for (int i = 0; i < 12; i++) begin
            b = PAYLOAD_BITS'($urandom);
            tx_q.push_back(b);
            bus_write(REG_DATA, 32'(b), "bp_write");
            if (i == 8) begin
                b = tx_q.pop_front();      // Head already in the serializer.
                check_status("bp_full_status");
                tx_q.push_front(b);
            end
        end
        for (int i = 0; i < 12; i++) begin
            wait_rx_level(1);
            rx_q.push_back(tx_q.pop_front());
            check_rx_byte("bp_read");
        end
        check_status("bp_status");

        loop_en = 1'b0;
        send_frame(PAYLOAD_BITS'($urandom), 1'b0);
        frame_m = 1'b1;
        check_status("frame_err_status");
        check_status("frame_err_cleared");

        for (int i = 0; i < 10; i++) begin
            b = PAYLOAD_BITS'($urandom);
            send_frame(b, 1'b1);
            if (rx_q.size() < FIFO_DEPTH) begin
                rx_q.push_back(b);
            end else begin
                overrun_m = 1'b1;
            end
        end
        check_status("overrun_status");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            check_rx_byte("overrun_read");
        end
        check_status("overrun_final_status");

        while (checked != issued) @(negedge clk);
        @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/uart_cfg_pkg.sv
hdl/uart_bus_pkg.sv
hdl/byte_chan_if.sv
hdl/byte_fifo.sv
hdl/uart_tx_path.sv
hdl/uart_rx_path.sv
hdl/uart_bus_regs.sv
hdl/uart_periph.sv
test/uart_periph_assert.sv
test/uart_periph_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module uart_periph_tb -o sim_uart
./obj_dir/sim_uart > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi
